// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_net_ctrl
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# a failing check ends in $fatal, which gives a nonzero exit status
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
rtl/net_pkg.sv
rtl/lease_timer.sv
rtl/link_fsm.sv
rtl/tx_arbiter.sv
rtl/tx_field_mux.sv
rtl/net_ctrl_top.sv
sim/tb_net_ctrl.sv

// ==== rtl/lease_timer.sv ====
// seconds base for the link fsm; ticks_per_second must be 2 or more, seconds wraps after 15
`timescale 1ns/10ps

module lease_timer #(
  parameter int ticks_per_second = 2_500_000
) (
  input  logic                          tx_clock,
  input  logic                          rst_n,
  input  net_pkg::timer_cmd_t           timer_cmd,
  output logic                          sec_tick,
  output logic [net_pkg::seconds_w-1:0] seconds,
  output logic                          dhcp_timeout,
  output logic                          renew_zero
);
  import net_pkg::*;

  typedef logic [$clog2(ticks_per_second)-1:0] presc_t;

  presc_t             presc;
  logic [renew_w-1:0] renew_cnt;

  // --------------------
  // prescaler
  // --------------------

  // counts down, one tick pulse per reload
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      presc    <= presc_t'(ticks_per_second - 1);
      sec_tick <= 1'b0;
    end else if (timer_cmd.restart_second) begin
      presc    <= presc_t'(ticks_per_second - 1);
      sec_tick <= 1'b0;
    end else if (presc == '0) begin
      presc    <= presc_t'(ticks_per_second - 1);
      sec_tick <= 1'b1;
    end else begin
      presc    <= presc - 1'b1;
      sec_tick <= 1'b0;
    end
  end

  // --------------------
  // elapsed seconds
  // --------------------

  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      seconds <= '0;
    end else if (timer_cmd.clear_seconds) begin
      seconds <= '0;
    end else if (timer_cmd.count_seconds && sec_tick) begin
      seconds <= seconds + 1'b1;
    end
  end

  // renewal countdown, load wins over count, stops at zero
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      renew_cnt <= '0;
    end else if (timer_cmd.load_renew) begin
      renew_cnt <= timer_cmd.renew_value;
    end else if (timer_cmd.count_renew && sec_tick && !renew_zero) begin
      renew_cnt <= renew_cnt - 1'b1;
    end
  end

  assign renew_zero   = (renew_cnt == '0);
  // no reply within the give-up window
  assign dhcp_timeout = (seconds == seconds_w'(dhcp_give_up_s));

endmodule

// ==== rtl/link_fsm.sv ====
// address acquisition and lease fsm; dhcp_success must be a one-cycle pulse, lease is used mod 2^18
`timescale 1ns/10ps

module link_fsm (
  input  logic                          tx_clock,
  input  logic                          rst_n,
  input  logic                          cfg_valid,
  input  logic [31:0]                   static_ip,
  input  logic [47:0]                   local_mac,
  input  logic                          phy_link,
  input  logic                          dhcp_success,
  input  net_pkg::dhcp_result_t         dhcp_result,
  input  logic                          sec_tick,
  input  logic [net_pkg::seconds_w-1:0] seconds,
  input  logic                          renew_zero,
  output net_pkg::timer_cmd_t           timer_cmd,
  output logic [31:0]                   local_ip,
  output logic                          network_down,
  output logic                          dhcp_tx_enable,
  output logic                          dhcp_rx_enable,
  output net_pkg::link_state_e          state
);
  import net_pkg::*;

  typedef logic [$clog2(retry_gap_cycles + 1)-1:0] gap_t;

  logic        static_ok;
  logic        link_lost;
  logic        retry_now;
  logic        give_up;
  logic [31:0] apipa_ip;
  gap_t        gap_cnt;

  // half the granted lease, or a default when none was given
  function automatic logic [renew_w-1:0] half_lease(input logic [31:0] lease);
    if (lease == 32'd0) begin
      return default_renew_s;
    end
    return renew_w'(lease >> 1);
  endfunction

  // static address usable unless 0.0.0.0 or broadcast
  assign static_ok = (static_ip != 32'd0) && (static_ip != 32'hFFFF_FFFF);
  assign link_lost = (state > st_phy_connect) && !phy_link;
  assign apipa_ip  = {apipa_prefix, local_mac[15:0]};

  // seconds still holds the old count on the tick
  // so 0, 2, 6 retransmit at 1, 3, 7
  assign retry_now = seconds inside {seconds_w'(0), seconds_w'(2), seconds_w'(6)};
  assign give_up   = (seconds == seconds_w'(dhcp_give_up_s - 1));

  // --------------------
  // state register
  // --------------------

  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      state        <= st_wait_config;
      network_down <= 1'b1;
      local_ip     <= '0;
      gap_cnt      <= '0;
    end else if (link_lost) begin
      // link gone, network down until it returns
      network_down <= 1'b1;
      state        <= st_phy_connect;
    end else begin
      case (state)
        st_wait_config: begin
          if (cfg_valid) begin
            state <= st_phy_connect;
          end
        end
        st_phy_connect: begin
          if (phy_link) begin
            state <= st_phy_settle;
          end
        end
        // one second for the link to settle
        st_phy_settle: begin
          if (sec_tick) begin
            if (static_ok) begin
              local_ip <= static_ip;
              state    <= st_running;
            end else begin
              // dhcp requires 0.0.0.0 as source
              local_ip <= '0;
              state    <= st_dhcp_request;
            end
          end
        end
        st_dhcp_request: begin
          state <= st_dhcp_wait;
        end
        st_dhcp_wait: begin
          if (dhcp_success) begin
            local_ip     <= dhcp_result.ip;
            network_down <= 1'b0;
            state        <= st_renew_wait;
          end else if (sec_tick && retry_now) begin
            gap_cnt <= gap_t'(retry_gap_cycles);
            state   <= st_dhcp_retry;
          end else if (sec_tick && give_up) begin
            // nobody answered, fall back to link-local
            local_ip <= apipa_ip;
            state    <= st_running;
          end
        end
        // short pause before the retransmit
        st_dhcp_retry: begin
          if (gap_cnt == '0) begin
            state <= st_dhcp_request;
          end else begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        end
        st_running: begin
          network_down <= 1'b0;
        end
        // network stays up through the whole renewal
        st_renew_wait: begin
          if (renew_zero) begin
            state <= st_renew_req;
          end
        end
        st_renew_req: begin
          state <= st_renew_ack;
        end
        st_renew_ack: begin
          if (dhcp_success || renew_zero) begin
            state <= st_renew_wait;
          end
        end
        default: begin
          state <= st_wait_config;
        end
      endcase
    end
  end

  // --------------------
  // timer commands
  // --------------------

  always_comb begin
    timer_cmd               = '0;
    timer_cmd.count_seconds = state inside {st_dhcp_request, st_dhcp_wait, st_dhcp_retry};
    timer_cmd.count_renew   = state inside {st_renew_wait, st_renew_ack};
    case (state)
      // settle second starts when the link comes up
      st_phy_connect: timer_cmd.restart_second = phy_link;
      st_phy_settle: begin
        if (sec_tick && !static_ok) begin
          timer_cmd.restart_second = 1'b1;
          timer_cmd.clear_seconds  = 1'b1;
        end
      end
      st_dhcp_wait: begin
        if (dhcp_success) begin
          timer_cmd.load_renew  = 1'b1;
          timer_cmd.renew_value = half_lease(dhcp_result.lease);
        end
      end
      // ack window
      st_renew_req: begin
        timer_cmd.restart_second = 1'b1;
        timer_cmd.load_renew     = 1'b1;
        timer_cmd.renew_value    = renew_ack_wait_s;
      end
      st_renew_ack: begin
        if (dhcp_success) begin
          timer_cmd.load_renew  = 1'b1;
          timer_cmd.renew_value = half_lease(dhcp_result.lease);
        end else if (renew_zero) begin
          // no ack, ask again later
          timer_cmd.load_renew  = 1'b1;
          timer_cmd.renew_value = renew_gap_s;
        end
      end
      default: ;
    endcase
  end

  // request states last one cycle
  assign dhcp_tx_enable = (state == st_dhcp_request) || (state == st_renew_req);
  // receive open while a reply is expected
  assign dhcp_rx_enable = state inside {st_dhcp_request, st_dhcp_wait,
                                        st_renew_req, st_renew_ack};

endmodule

// ==== rtl/net_ctrl_top.sv ====
// link controller top; single clock, dhcp and frame engines sit outside and use the handshakes
`timescale 1ns/10ps

module net_ctrl_top #(
  parameter int ticks_per_second = 2_500_000
) (
  input  logic                          tx_clock,
  input  logic                          rst_n,
  // configuration and link
  input  logic                          cfg_valid,
  input  logic [31:0]                   static_ip,
  input  logic [47:0]                   local_mac,
  input  logic                          phy_link,
  // external dhcp engine
  input  logic                          dhcp_success,
  input  net_pkg::dhcp_result_t         dhcp_result,
  // transmit sources
  input  net_pkg::tx_req_t              tx_req,
  input  net_pkg::dest_fields_t         arp_dest,
  input  net_pkg::dest_fields_t         icmp_dest,
  input  net_pkg::dest_fields_t         dhcp_dest,
  input  net_pkg::dest_fields_t         udp_dest,
  input  logic                          run,
  input  logic                          phy_tx_active,
  // address status
  output logic [31:0]                   local_ip,
  output logic                          network_down,
  output logic                          dhcp_tx_enable,
  output logic                          dhcp_rx_enable,
  output logic [net_pkg::seconds_w-1:0] dhcp_seconds,
  output logic                          dhcp_timeout,
  // transmit select
  output net_pkg::tx_proto_e            tx_proto,
  output logic                          tx_start,
  output net_pkg::tx_header_t           tx_header
);
  import net_pkg::*;

  timer_cmd_t timer_cmd;
  logic       sec_tick;
  logic       renew_zero;

  // --------------------
  // address acquisition
  // --------------------

  link_fsm u_link_fsm (
    .tx_clock       (tx_clock),
    .rst_n          (rst_n),
    .cfg_valid      (cfg_valid),
    .static_ip      (static_ip),
    .local_mac      (local_mac),
    .phy_link       (phy_link),
    .dhcp_success   (dhcp_success),
    .dhcp_result    (dhcp_result),
    .sec_tick       (sec_tick),
    .seconds        (dhcp_seconds),
    .renew_zero     (renew_zero),
    .timer_cmd      (timer_cmd),
    .local_ip       (local_ip),
    .network_down   (network_down),
    .dhcp_tx_enable (dhcp_tx_enable),
    .dhcp_rx_enable (dhcp_rx_enable),
    .state          ()
  );

  lease_timer #(
    .ticks_per_second (ticks_per_second)
  ) u_lease_timer (
    .tx_clock     (tx_clock),
    .rst_n        (rst_n),
    .timer_cmd    (timer_cmd),
    .sec_tick     (sec_tick),
    .seconds      (dhcp_seconds),
    .dhcp_timeout (dhcp_timeout),
    .renew_zero   (renew_zero)
  );

  // --------------------
  // transmit path
  // --------------------

  tx_arbiter u_tx_arbiter (
    .tx_clock      (tx_clock),
    .rst_n         (rst_n),
    .tx_req        (tx_req),
    .phy_tx_active (phy_tx_active),
    .tx_proto      (tx_proto),
    .tx_start      (tx_start)
  );

  tx_field_mux u_tx_field_mux (
    .tx_clock  (tx_clock),
    .rst_n     (rst_n),
    .tx_proto  (tx_proto),
    .run       (run),
    .arp_dest  (arp_dest),
    .icmp_dest (icmp_dest),
    .dhcp_dest (dhcp_dest),
    .udp_dest  (udp_dest),
    .tx_header (tx_header)
  );

endmodule

// ==== rtl/net_pkg.sv ====
// shared types and constants for the link controller; all timing in whole seconds, 18-bit lease
package net_pkg;

  // --------------------
  // constants
  // --------------------

  // udp ports
  localparam logic [15:0] dhcp_client_port = 16'd68;
  localparam logic [15:0] app_local_port   = 16'd1024;

  // counter widths
  localparam int seconds_w = 4;
  localparam int renew_w   = 18;

  // lease handling, all in seconds
  localparam logic [renew_w-1:0] default_renew_s  = 18'd43200;
  localparam logic [renew_w-1:0] renew_ack_wait_s = 18'd20;
  localparam logic [renew_w-1:0] renew_gap_s      = 18'd300;

  // pause before a dhcp retransmit, in clock cycles
  localparam int retry_gap_cycles = 16;

  // give up on dhcp after this many seconds
  localparam int dhcp_give_up_s = 15;

  // link-local prefix 169.254
  localparam logic [15:0] apipa_prefix = 16'hA9FE;

  // --------------------
  // types
  // --------------------

  // controller states, order matters for the link-loss compare
  typedef enum logic [3:0] {
    st_wait_config,
    st_phy_connect,
    st_phy_settle,
    st_dhcp_request,
    st_dhcp_wait,
    st_dhcp_retry,
    st_running,
    st_renew_wait,
    st_renew_req,
    st_renew_ack
  } link_state_e;

  // transmit protocols
  typedef enum logic [1:0] {
    pt_arp,
    pt_icmp,
    pt_dhcp,
    pt_udp
  } tx_proto_e;

  // one request bit per frame source
  typedef struct packed {
    logic arp;
    logic icmp;
    logic dhcp;
    logic udp;
  } tx_req_t;

  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
  } dest_fields_t;

  // result of an external dhcp exchange
  typedef struct packed {
    logic [31:0] ip;
    logic [31:0] lease;
  } dhcp_result_t;

  typedef struct packed {
    dest_fields_t dest;
    logic [15:0]  local_port;
  } tx_header_t;

  // fsm to timer commands
  typedef struct packed {
    logic               restart_second;
    logic               clear_seconds;
    logic               count_seconds;
    logic               load_renew;
    logic [renew_w-1:0] renew_value;
    logic               count_renew;
  } timer_cmd_t;

endpackage

// ==== rtl/tx_arbiter.sv ====
// fixed-priority transmit arbiter; requests are levels held until their frame starts
`timescale 1ns/10ps

module tx_arbiter (
  input  logic                tx_clock,
  input  logic                rst_n,
  input  net_pkg::tx_req_t    tx_req,
  input  logic                phy_tx_active,
  output net_pkg::tx_proto_e  tx_proto,
  output logic                tx_start
);
  import net_pkg::*;

  logic      tx_ready;
  logic      req_any;
  tx_proto_e req_proto;

  // --------------------
  // priority decode
  // --------------------

  // arp first, udp last
  always_comb begin
    req_any   = |tx_req;
    req_proto = pt_udp;
    if (tx_req.arp) begin
      req_proto = pt_arp;
    end else if (tx_req.icmp) begin
      req_proto = pt_icmp;
    end else if (tx_req.dhcp) begin
      req_proto = pt_dhcp;
    end
  end

  // --------------------
  // ready / start / active
  // --------------------

  // latch winner, start one cycle later, hold until the phy sends
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      tx_ready <= 1'b0;
      tx_start <= 1'b0;
      tx_proto <= pt_arp;
    end else if (phy_tx_active) begin
      tx_ready <= 1'b0;
      tx_start <= 1'b0;
    end else if (tx_ready) begin
      tx_start <= 1'b1;
    end else if (req_any) begin
      tx_proto <= req_proto;
      tx_ready <= 1'b1;
    end
  end

endmodule

// ==== rtl/tx_field_mux.sv ====
// header field select per protocol; udp destination is frozen while run is high
`timescale 1ns/10ps

module tx_field_mux (
  input  logic                  tx_clock,
  input  logic                  rst_n,
  input  net_pkg::tx_proto_e    tx_proto,
  input  logic                  run,
  input  net_pkg::dest_fields_t arp_dest,
  input  net_pkg::dest_fields_t icmp_dest,
  input  net_pkg::dest_fields_t dhcp_dest,
  input  net_pkg::dest_fields_t udp_dest,
  output net_pkg::tx_header_t   tx_header
);
  import net_pkg::*;

  dest_fields_t udp_hold;

  // --------------------
  // udp destination hold
  // --------------------

  // follows udp_dest while stopped
  // keeps the last value once run is set
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      udp_hold <= '0;
    end else if (!run) begin
      udp_hold <= udp_dest;
    end
  end

  // --------------------
  // field select
  // --------------------

  always_comb begin
    tx_header.local_port = app_local_port;
    case (tx_proto)
      pt_arp: begin
        tx_header.dest = arp_dest;
      end
      pt_icmp: begin
        tx_header.dest = icmp_dest;
      end
      // dhcp goes out from the client port
      pt_dhcp: begin
        tx_header.dest       = dhcp_dest;
        tx_header.local_port = dhcp_client_port;
      end
      default: begin
        tx_header.dest = udp_hold;
      end
    endcase
  end

endmodule

// ==== sim/tb_net_ctrl.sv ====
// directed testbench for net_ctrl_top; 20-cycle seconds base, stops at the first failing check
`timescale 1ns/10ps

module tb_net_ctrl;
  import net_pkg::*;

  localparam int tps = 20;
  // tests take about 1500 cycles with margin, apipa longest at ~350, times 4
  localparam int timeout_cycles = 4 * 1500;

  logic                 tx_clock;
  logic                 rst_n;
  logic                 cfg_valid;
  logic [31:0]          static_ip;
  logic [47:0]          local_mac;
  logic                 phy_link;
  logic                 dhcp_success;
  dhcp_result_t         dhcp_result;
  tx_req_t              tx_req;
  dest_fields_t         arp_dest;
  dest_fields_t         icmp_dest;
  dest_fields_t         dhcp_dest;
  dest_fields_t         udp_dest;
  logic                 run;
  logic                 phy_tx_active;
  logic [31:0]          local_ip;
  logic                 network_down;
  logic                 dhcp_tx_enable;
  logic                 dhcp_rx_enable;
  logic [seconds_w-1:0] dhcp_seconds;
  logic                 dhcp_timeout;
  tx_proto_e            tx_proto;
  logic                 tx_start;
  tx_header_t           tx_header;

  logic [31:0]          lfsr_state;
  int                   cycle_count = 0;

  net_ctrl_top #(
    .ticks_per_second (tps)
  ) dut (.*);

  // --------------------
  // clock and timeout
  // --------------------

  initial tx_clock = 1'b0;
  always #5 tx_clock = ~tx_clock;

  always @(posedge tx_clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("STATUS: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  // --------------------
  // helpers
  // --------------------

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic dest_fields_t random_dest();
    dest_fields_t d;
    d.mac  = 48'(random_bits(48));
    d.ip   = 32'(random_bits(32));
    d.port = 16'(random_bits(16));
    return d;
  endfunction

  // header expected for a frame, udp taken live since run stays low there
  function automatic tx_header_t expected_header(input tx_proto_e p);
    tx_header_t h;
    h.local_port = 16'd1024;
    case (p)
      pt_arp:  h.dest = arp_dest;
      pt_icmp: h.dest = icmp_dest;
      pt_dhcp: begin
        h.dest       = dhcp_dest;
        h.local_port = 16'd68;
      end
      default: h.dest = udp_dest;
    endcase
    return h;
  endfunction

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at the first failing check");
  endtask

  // inputs change 1 ns after the edge
  task automatic step_cycle();
    @(posedge tx_clock);
    #1;
  endtask

  task automatic apply_reset();
    rst_n        = 1'b0;
    cfg_valid    = 1'b0;
    phy_link     = 1'b0;
    dhcp_success = 1'b0;
    repeat (5) step_cycle();
    rst_n = 1'b1;
    assert (network_down && !dhcp_tx_enable && !dhcp_rx_enable && !tx_start)
      else report_error("outputs not at their reset values");
  endtask

  task automatic drop_request(input tx_proto_e p);
    case (p)
      pt_arp:  tx_req.arp  = 1'b0;
      pt_icmp: tx_req.icmp = 1'b0;
      pt_dhcp: tx_req.dhcp = 1'b0;
      default: tx_req.udp  = 1'b0;
    endcase
  endtask

  task automatic send_dhcp_success(input logic [31:0] ip, input logic [31:0] lease);
    dhcp_success      = 1'b1;
    dhcp_result.ip    = ip;
    dhcp_result.lease = lease;
    step_cycle();
    dhcp_success = 1'b0;
    step_cycle();
  endtask

  // settle second plus slack, never a dhcp request
  task automatic wait_static_up(input logic [31:0] ip);
    int n;
    n = 0;
    while (network_down && n < 2 * tps + 10) begin
      step_cycle();
      n++;
      assert (!dhcp_tx_enable) else report_error("dhcp_tx_enable pulsed with a static address");
    end
    assert (!network_down) else report_error("network_down still high 2 seconds after link up");
    assert (local_ip == ip)
      else report_error($sformatf("local_ip %h, expected %h", local_ip, ip));
    assert (!dhcp_rx_enable) else report_error("dhcp_rx_enable high with a static address");
  endtask

  task automatic wait_dhcp_pulse(input int limit, input logic stay_up, output int n);
    n = 0;
    while (!dhcp_tx_enable && n < limit) begin
      step_cycle();
      n++;
      assert (!stay_up || !network_down) else report_error("network_down rose during renewal");
    end
    assert (dhcp_tx_enable) else report_error("no dhcp_tx_enable pulse within the expected time");
  endtask

  // --------------------
  // tests
  // --------------------

  task automatic test_static();
    apply_reset();
    static_ip = {8'd10, 24'(random_bits(24))};
    cfg_valid = 1'b1;
    phy_link  = 1'b1;
    wait_static_up(static_ip);
  endtask

  // continues from a running static link
  task automatic test_link_loss();
    phy_link = 1'b0;
    step_cycle();
    assert (network_down) else report_error("network_down not raised the cycle after link loss");
    repeat (3) step_cycle();
    phy_link = 1'b1;
    wait_static_up(static_ip);
  endtask

  // continues from a running static link, relinked without a static address
  task automatic test_dhcp();
    int          n;
    logic [31:0] ip;
    logic [31:0] other_ip;
    ip        = 32'(random_bits(32));
    other_ip  = 32'(random_bits(32));
    phy_link  = 1'b0;
    static_ip = 32'd0;
    step_cycle();
    phy_link  = 1'b1;
    wait_dhcp_pulse(2 * tps + 10, 1'b0, n);
    assert (local_ip == 32'd0)
      else report_error($sformatf("local_ip %h during dhcp, expected 0", local_ip));
    assert (!dhcp_timeout) else report_error("dhcp_timeout high at the first dhcp request");
    step_cycle();
    assert (!dhcp_tx_enable) else report_error("dhcp_tx_enable high for more than one cycle");
    assert (dhcp_rx_enable) else report_error("dhcp_rx_enable low while waiting for the reply");
    // lease 4 gives a renewal after 2 seconds
    send_dhcp_success(ip, 32'd4);
    assert (local_ip == ip)
      else report_error($sformatf("local_ip %h, expected granted %h", local_ip, ip));
    assert (!network_down) else report_error("network_down still high after dhcp success");
    assert (!dhcp_rx_enable) else report_error("dhcp_rx_enable high after the lease was granted");
    wait_dhcp_pulse(3 * tps + 10, 1'b1, n);
    assert (n >= tps)
      else report_error($sformatf("renew request after %0d cycles, expected about 2 s", n));
    // acknowledge arrives in the ack window
    step_cycle();
    assert (dhcp_rx_enable) else report_error("dhcp_rx_enable low in the renew ack window");
    send_dhcp_success(other_ip, 32'd4);
    assert (local_ip == ip && !network_down)
      else report_error($sformatf("local_ip %h after renew ack, expected %h", local_ip, ip));
  endtask

  task automatic test_apipa();
    int                   pulses;
    int                   n;
    logic [seconds_w-1:0] pulse_s [4];
    apply_reset();
    // first request, then retransmits at 1, 3 and 7 s
    pulse_s   = '{4'd0, 4'd1, 4'd3, 4'd7};
    local_mac = 48'(random_bits(48));
    static_ip = 32'hFFFF_FFFF;
    cfg_valid = 1'b1;
    phy_link  = 1'b1;
    pulses    = 0;
    n         = 0;
    while (network_down && n < 17 * tps + 50) begin
      step_cycle();
      n++;
      if (dhcp_tx_enable) begin
        assert (pulses < 4 && dhcp_seconds == pulse_s[pulses])
          else report_error($sformatf("dhcp request %0d at second %0d", pulses, dhcp_seconds));
        pulses++;
      end
    end
    assert (!network_down) else report_error("no link-local fallback after 15 seconds");
    assert (pulses == 4)
      else report_error($sformatf("%0d dhcp requests, expected 4", pulses));
    assert (local_ip == {16'hA9FE, local_mac[15:0]})
      else report_error($sformatf("local_ip %h, expected 169.254 and mac low half", local_ip));
    assert (dhcp_timeout) else report_error("dhcp_timeout low after the fallback");
    assert (dhcp_seconds == 4'd15)
      else report_error($sformatf("dhcp_seconds %0d after the fallback, expected 15",
                                  dhcp_seconds));
    assert (!dhcp_rx_enable) else report_error("dhcp_rx_enable high after the fallback");
  endtask

  task automatic test_arbitration();
    tx_proto_e order [4];
    order     = '{pt_arp, pt_icmp, pt_dhcp, pt_udp};
    arp_dest  = random_dest();
    icmp_dest = random_dest();
    dhcp_dest = random_dest();
    udp_dest  = random_dest();
    tx_req    = 4'b1111;
    foreach (order[i]) begin
      step_cycle();
      assert (!tx_start) else report_error("tx_start one cycle early");
      step_cycle();
      assert (tx_start)
        else report_error($sformatf("no tx_start 2 cycles after the arbiter was free (%0d)", i));
      assert (tx_proto == order[i])
        else report_error($sformatf("tx_proto %s, expected %s", tx_proto.name(),
                                    order[i].name()));
      assert (tx_header == expected_header(order[i]))
        else report_error($sformatf("tx_header %h for %s", tx_header, order[i].name()));
      // held until the phy reports it is sending
      repeat (3) begin
        step_cycle();
        assert (tx_start) else report_error("tx_start dropped before phy_tx_active");
      end
      phy_tx_active = 1'b1;
      drop_request(order[i]);
      step_cycle();
      assert (!tx_start) else report_error("tx_start still high after phy_tx_active");
      phy_tx_active = 1'b0;
    end
  endtask

  // tx_proto is left on udp by the arbitration test
  task automatic test_udp_hold();
    dest_fields_t held;
    dest_fields_t fresh;
    held  = udp_dest;
    fresh = random_dest();
    run   = 1'b1;
    step_cycle();
    udp_dest = fresh;
    repeat (2) step_cycle();
    assert (tx_proto == pt_udp && tx_header.dest == held)
      else report_error($sformatf("udp dest %h while run high, expected %h",
                                  tx_header.dest, held));
    assert (tx_header.local_port == 16'd1024)
      else report_error($sformatf("udp local_port %0d, expected 1024", tx_header.local_port));
    run = 1'b0;
    step_cycle();
    assert (tx_header.dest == fresh)
      else report_error($sformatf("udp dest %h after run fell, expected %h",
                                  tx_header.dest, fresh));
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    lfsr_state    = 32'h8585_a277;
    rst_n         = 1'b0;
    cfg_valid     = 1'b0;
    static_ip     = 32'd0;
    local_mac     = 48'h02_00_00_00_00_01;
    phy_link      = 1'b0;
    dhcp_success  = 1'b0;
    dhcp_result   = '0;
    tx_req        = '0;
    arp_dest      = '0;
    icmp_dest     = '0;
    dhcp_dest     = '0;
    udp_dest      = '0;
    run           = 1'b0;
    phy_tx_active = 1'b0;
    test_static();
    test_link_loss();
    test_dhcp();
    test_apipa();
    test_arbitration();
    test_udp_hold();
    $display("STATUS: PASS");
    $finish;
  end

endmodule
